// File: source/vsi_settings.svh
`ifndef VSI_SETTINGS_SVH
`define VSI_SETTINGS_SVH

// Number of inverter phases and width of period, duty and compare values
`define VSI_N_PHASES 4
`define VSI_DATA_WIDTH 16

// Width of the PWM generator register index
`define VSI_REG_ADDR_WIDTH 4

// Register offsets inside the PWM generator
`define VSI_REG_CONTROL 0
`define VSI_REG_COUNTER_RESET 1
`define VSI_REG_PERIOD 2
`define VSI_REG_COMPARE_LOW_BASE 3
`define VSI_REG_COMPARE_HIGH_BASE 7

// Values of the control register
`define VSI_CTRL_STOPPED 0
`define VSI_CTRL_RUN 1

// Period written by the configure sequence
`define VSI_DEFAULT_PERIOD 100

`endif

// File: source/pwm_map_pkg.sv
`default_nettype none

`include "vsi_settings.svh"

package pwm_map_pkg;

    // Register index of the PWM generator, one compare pair per phase
    typedef enum logic [`VSI_REG_ADDR_WIDTH-1:0] {
        reg_control = `VSI_REG_CONTROL,
        reg_counter_reset = `VSI_REG_COUNTER_RESET,
        reg_period = `VSI_REG_PERIOD,
        reg_compare_low_0 = `VSI_REG_COMPARE_LOW_BASE,
        reg_compare_low_1 = `VSI_REG_COMPARE_LOW_BASE + 1,
        reg_compare_low_2 = `VSI_REG_COMPARE_LOW_BASE + 2,
        reg_compare_low_3 = `VSI_REG_COMPARE_LOW_BASE + 3,
        reg_compare_high_0 = `VSI_REG_COMPARE_HIGH_BASE,
        reg_compare_high_1 = `VSI_REG_COMPARE_HIGH_BASE + 1,
        reg_compare_high_2 = `VSI_REG_COMPARE_HIGH_BASE + 2,
        reg_compare_high_3 = `VSI_REG_COMPARE_HIGH_BASE + 3
    } pwm_register_t;

    // Values held by the control register
    typedef enum logic [`VSI_DATA_WIDTH-1:0] {
        ctrl_stopped = `VSI_CTRL_STOPPED,
        ctrl_run = `VSI_CTRL_RUN
    } pwm_control_t;

endpackage

`default_nettype wire

// File: source/modulator_ctrl_pkg.sv
`default_nettype none

package modulator_ctrl_pkg;

    // States of the register write arbiter
    typedef enum logic [1:0] {
        idle,
        issue,
        wait_ready,
        next
    } arbiter_state_t;

    // Kinds of request the configuration sequencer can raise
    typedef enum logic [1:0] {
        req_configure,
        req_start,
        req_stop
    } request_kind_t;

endpackage

`default_nettype wire

// File: source/compare_calculator.sv
`timescale 1ns/1ns
`default_nettype none

`include "vsi_settings.svh"

module compare_calculator (
    input logic clock,
    input logic reset,
    input logic [`VSI_N_PHASES-1:0] update,
    input logic [`VSI_DATA_WIDTH-1:0] period,
    input logic [`VSI_DATA_WIDTH-1:0] duty [`VSI_N_PHASES],
    input logic modulator_status,
    output logic compare_valid,
    output logic [`VSI_DATA_WIDTH-1:0] compare_low [`VSI_N_PHASES],
    output logic [`VSI_DATA_WIDTH-1:0] compare_high [`VSI_N_PHASES],
    output logic [`VSI_DATA_WIDTH-1:0] batch_period
);

    logic update_pending;
    logic calculate;

    // Duty changes are only applied while the modulator is stopped
    assign calculate = update_pending && !modulator_status;

    always_ff @(posedge clock) begin
        if (!reset) begin
            update_pending <= 1'b0;
            compare_valid <= 1'b0;
        end else begin
            compare_valid <= calculate;
            if (calculate) begin
                // A strobe in the same cycle starts a fresh pending update
                update_pending <= |update;
            end else begin
                update_pending <= update_pending | (|update);
            end
        end
    end

    // Centre aligned pair around half the period
    always_ff @(posedge clock) begin
        if (calculate) begin
            batch_period <= period;
            for (int i = 0; i < `VSI_N_PHASES; i++) begin
                compare_low[i] <= (period >> 1) - (duty[i] >> 1);
                compare_high[i] <= (period >> 1) + (duty[i] >> 1);
            end
        end
    end

endmodule

`default_nettype wire

// File: source/config_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

`include "vsi_settings.svh"

module config_sequencer (
    input logic clock,
    input logic reset,
    input logic configure,
    input logic start,
    input logic stop,
    input logic seq_accept,
    output logic seq_request,
    output pwm_map_pkg::pwm_register_t seq_address,
    output logic [`VSI_DATA_WIDTH-1:0] seq_data,
    output logic done,
    output logic modulator_status
);

    localparam logic [1:0] last_config_word = 2'd2;

    modulator_ctrl_pkg::request_kind_t request_kind;
    logic [1:0] word_count;

    always_ff @(posedge clock) begin
        if (!reset) begin
            seq_request <= 1'b0;
            done <= 1'b0;
            modulator_status <= 1'b0;
            request_kind <= modulator_ctrl_pkg::req_configure;
            word_count <= 2'd0;
        end else begin
            done <= 1'b0;
            if (seq_request) begin
                if (seq_accept) begin
                    if (request_kind == modulator_ctrl_pkg::req_configure &&
                            word_count != last_config_word) begin
                        word_count <= word_count + 2'd1;
                    end else begin
                        seq_request <= 1'b0;
                        done <= (request_kind == modulator_ctrl_pkg::req_configure);
                    end
                end
            end else if (configure) begin
                request_kind <= modulator_ctrl_pkg::req_configure;
                word_count <= 2'd0;
                seq_request <= 1'b1;
            end else if (start) begin
                request_kind <= modulator_ctrl_pkg::req_start;
                word_count <= 2'd0;
                seq_request <= 1'b1;
                modulator_status <= 1'b1;
            end else if (stop) begin
                request_kind <= modulator_ctrl_pkg::req_stop;
                word_count <= 2'd0;
                seq_request <= 1'b1;
                modulator_status <= 1'b0;
            end
        end
    end

    // Word presented to the arbiter, held until it is accepted
    always_comb begin
        seq_address = pwm_map_pkg::reg_control;
        seq_data = pwm_map_pkg::ctrl_stopped;
        case (request_kind)
            modulator_ctrl_pkg::req_configure: begin
                if (word_count == 2'd1) begin
                    seq_address = pwm_map_pkg::reg_counter_reset;
                    seq_data = `VSI_DATA_WIDTH'(1);
                end else if (word_count == last_config_word) begin
                    seq_address = pwm_map_pkg::reg_period;
                    seq_data = `VSI_DATA_WIDTH'(`VSI_DEFAULT_PERIOD);
                end
            end
            modulator_ctrl_pkg::req_start: begin
                seq_data = pwm_map_pkg::ctrl_run;
            end
            default: begin
                seq_data = pwm_map_pkg::ctrl_stopped;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/register_write_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "vsi_settings.svh"

module register_write_arbiter (
    input logic clock,
    input logic reset,
    input logic seq_request,
    input pwm_map_pkg::pwm_register_t seq_address,
    input logic [`VSI_DATA_WIDTH-1:0] seq_data,
    output logic seq_accept,
    input logic compare_valid,
    input logic [`VSI_DATA_WIDTH-1:0] compare_low [`VSI_N_PHASES],
    input logic [`VSI_DATA_WIDTH-1:0] compare_high [`VSI_N_PHASES],
    input logic [`VSI_DATA_WIDTH-1:0] batch_period,
    output pwm_map_pkg::pwm_register_t write_address,
    output logic [`VSI_DATA_WIDTH-1:0] write_data,
    output logic write_valid,
    input logic write_ready
);

    // Period plus a low and a high compare per phase
    localparam logic [3:0] last_index = 4'(2 * `VSI_N_PHASES);

    modulator_ctrl_pkg::arbiter_state_t state;
    logic batch_pending;
    logic batch_active;
    logic [3:0] batch_index;
    logic [`VSI_DATA_WIDTH-1:0] period_q;
    logic [`VSI_DATA_WIDTH-1:0] low_q [`VSI_N_PHASES];
    logic [`VSI_DATA_WIDTH-1:0] high_q [`VSI_N_PHASES];
    pwm_map_pkg::pwm_register_t batch_address;
    logic [`VSI_DATA_WIDTH-1:0] batch_data;

    always_ff @(posedge clock) begin
        if (compare_valid) begin
            period_q <= batch_period;
            low_q <= compare_low;
            high_q <= compare_high;
        end
    end

    // Batch order is period, then the low compares, then the high compares
    always_comb begin
        batch_address = pwm_map_pkg::reg_period;
        batch_data = period_q;
        case (batch_index)
            4'd1: begin
                batch_address = pwm_map_pkg::reg_compare_low_0;
                batch_data = low_q[0];
            end
            4'd2: begin
                batch_address = pwm_map_pkg::reg_compare_low_1;
                batch_data = low_q[1];
            end
            4'd3: begin
                batch_address = pwm_map_pkg::reg_compare_low_2;
                batch_data = low_q[2];
            end
            4'd4: begin
                batch_address = pwm_map_pkg::reg_compare_low_3;
                batch_data = low_q[3];
            end
            4'd5: begin
                batch_address = pwm_map_pkg::reg_compare_high_0;
                batch_data = high_q[0];
            end
            4'd6: begin
                batch_address = pwm_map_pkg::reg_compare_high_1;
                batch_data = high_q[1];
            end
            4'd7: begin
                batch_address = pwm_map_pkg::reg_compare_high_2;
                batch_data = high_q[2];
            end
            4'd8: begin
                batch_address = pwm_map_pkg::reg_compare_high_3;
                batch_data = high_q[3];
            end
            default: begin
                batch_address = pwm_map_pkg::reg_period;
                batch_data = period_q;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= modulator_ctrl_pkg::idle;
            write_valid <= 1'b0;
            seq_accept <= 1'b0;
            batch_pending <= 1'b0;
            batch_active <= 1'b0;
            batch_index <= 4'd0;
        end else begin
            seq_accept <= 1'b0;
            if (compare_valid) begin
                batch_pending <= 1'b1;
            end
            case (state)
                modulator_ctrl_pkg::idle: begin
                    // Sequencer words win over a waiting compare batch
                    if (seq_request) begin
                        batch_active <= 1'b0;
                        state <= modulator_ctrl_pkg::issue;
                    end else if (batch_pending) begin
                        batch_active <= 1'b1;
                        batch_index <= 4'd0;
                        batch_pending <= compare_valid;
                        state <= modulator_ctrl_pkg::issue;
                    end
                end
                modulator_ctrl_pkg::issue: begin
                    write_valid <= 1'b1;
                    if (batch_active) begin
                        write_address <= batch_address;
                        write_data <= batch_data;
                    end else begin
                        write_address <= seq_address;
                        write_data <= seq_data;
                        seq_accept <= 1'b1;
                    end
                    state <= modulator_ctrl_pkg::wait_ready;
                end
                modulator_ctrl_pkg::wait_ready: begin
                    if (write_ready) begin
                        write_valid <= 1'b0;
                        state <= modulator_ctrl_pkg::next;
                    end
                end
                modulator_ctrl_pkg::next: begin
                    // Ready comes back after its gap cycle
                    if (write_ready) begin
                        if (batch_active && batch_index != last_index) begin
                            batch_index <= batch_index + 4'd1;
                            state <= modulator_ctrl_pkg::issue;
                        end else begin
                            batch_active <= 1'b0;
                            state <= modulator_ctrl_pkg::idle;
                        end
                    end
                end
                default: begin
                    state <= modulator_ctrl_pkg::idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/pwm_generator.sv
`timescale 1ns/1ns
`default_nettype none

`include "vsi_settings.svh"

module pwm_generator (
    input logic clock,
    input logic reset,
    input pwm_map_pkg::pwm_register_t write_address,
    input logic [`VSI_DATA_WIDTH-1:0] write_data,
    input logic write_valid,
    output logic write_ready,
    output logic [`VSI_N_PHASES-1:0] pwm
);

    pwm_map_pkg::pwm_control_t control;
    logic [`VSI_DATA_WIDTH-1:0] period_reg;
    logic [`VSI_DATA_WIDTH-1:0] compare_low [`VSI_N_PHASES];
    logic [`VSI_DATA_WIDTH-1:0] compare_high [`VSI_N_PHASES];
    logic [`VSI_DATA_WIDTH-1:0] counter;
    logic write_fire;
    logic counter_clear;
    logic running;

    assign write_fire = write_valid && write_ready;
    assign counter_clear = write_fire && (write_address == pwm_map_pkg::reg_counter_reset);
    assign running = (control == pwm_map_pkg::ctrl_run);

    // Period and compare registers
    always_ff @(posedge clock) begin
        if (write_fire) begin
            case (write_address)
                pwm_map_pkg::reg_period: period_reg <= write_data;
                pwm_map_pkg::reg_compare_low_0: compare_low[0] <= write_data;
                pwm_map_pkg::reg_compare_low_1: compare_low[1] <= write_data;
                pwm_map_pkg::reg_compare_low_2: compare_low[2] <= write_data;
                pwm_map_pkg::reg_compare_low_3: compare_low[3] <= write_data;
                pwm_map_pkg::reg_compare_high_0: compare_high[0] <= write_data;
                pwm_map_pkg::reg_compare_high_1: compare_high[1] <= write_data;
                pwm_map_pkg::reg_compare_high_2: compare_high[2] <= write_data;
                pwm_map_pkg::reg_compare_high_3: compare_high[3] <= write_data;
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            control <= pwm_map_pkg::ctrl_stopped;
            counter <= '0;
            write_ready <= 1'b0;
            pwm <= '0;
        end else begin
            // Ready drops for exactly one cycle after each accepted write
            write_ready <= !write_fire;
            if (write_fire && write_address == pwm_map_pkg::reg_control) begin
                control <= pwm_map_pkg::pwm_control_t'(write_data);
            end

            if (!running || counter_clear) begin
                counter <= '0;
            end else if (counter >= period_reg - `VSI_DATA_WIDTH'(1)) begin
                counter <= '0;
            end else begin
                counter <= counter + `VSI_DATA_WIDTH'(1);
            end

            for (int i = 0; i < `VSI_N_PHASES; i++) begin
                pwm[i] <= running && (counter >= compare_low[i]) && (counter < compare_high[i]);
            end
        end
    end

endmodule

`default_nettype wire

// File: source/vsi_modulation_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "vsi_settings.svh"

module vsi_modulation_top (
    input logic clock,
    input logic reset,
    input logic configure,
    input logic start,
    input logic stop,
    input logic [`VSI_N_PHASES-1:0] update,
    input logic [`VSI_DATA_WIDTH-1:0] period,
    input logic [`VSI_DATA_WIDTH-1:0] duty [`VSI_N_PHASES],
    output logic done,
    output logic modulator_status,
    output logic [`VSI_N_PHASES-1:0] pwm
);

    logic compare_valid;
    logic [`VSI_DATA_WIDTH-1:0] compare_low [`VSI_N_PHASES];
    logic [`VSI_DATA_WIDTH-1:0] compare_high [`VSI_N_PHASES];
    logic [`VSI_DATA_WIDTH-1:0] batch_period;

    logic seq_request;
    logic seq_accept;
    pwm_map_pkg::pwm_register_t seq_address;
    logic [`VSI_DATA_WIDTH-1:0] seq_data;

    pwm_map_pkg::pwm_register_t write_address;
    logic [`VSI_DATA_WIDTH-1:0] write_data;
    logic write_valid;
    logic write_ready;

    compare_calculator u_compare_calculator (
        .clock(clock),
        .reset(reset),
        .update(update),
        .period(period),
        .duty(duty),
        .modulator_status(modulator_status),
        .compare_valid(compare_valid),
        .compare_low(compare_low),
        .compare_high(compare_high),
        .batch_period(batch_period)
    );

    config_sequencer u_config_sequencer (
        .clock(clock),
        .reset(reset),
        .configure(configure),
        .start(start),
        .stop(stop),
        .seq_accept(seq_accept),
        .seq_request(seq_request),
        .seq_address(seq_address),
        .seq_data(seq_data),
        .done(done),
        .modulator_status(modulator_status)
    );

    // Both producers share the single register write bus
    register_write_arbiter u_register_write_arbiter (
        .clock(clock),
        .reset(reset),
        .seq_request(seq_request),
        .seq_address(seq_address),
        .seq_data(seq_data),
        .seq_accept(seq_accept),
        .compare_valid(compare_valid),
        .compare_low(compare_low),
        .compare_high(compare_high),
        .batch_period(batch_period),
        .write_address(write_address),
        .write_data(write_data),
        .write_valid(write_valid),
        .write_ready(write_ready)
    );

    pwm_generator u_pwm_generator (
        .clock(clock),
        .reset(reset),
        .write_address(write_address),
        .write_data(write_data),
        .write_valid(write_valid),
        .write_ready(write_ready),
        .pwm(pwm)
    );

endmodule

`default_nettype wire

// File: testbench/pwm_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "vsi_settings.svh"

module pwm_checker #(
    parameter int phase_limit = 512
) (
    input logic clock,
    input logic reset,
    input logic done,
    input logic modulator_status,
    input logic [`VSI_N_PHASES-1:0] pwm,
    input logic [8*24-1:0] test_name,
    input logic expected_status,
    input logic done_window,
    input logic pwm_quiet,
    input logic measure_request,
    input logic [`VSI_DATA_WIDTH-1:0] measure_period,
    input logic [`VSI_DATA_WIDTH-1:0] measure_duty [`VSI_N_PHASES],
    output logic measure_done,
    output int error_count
);

    int level_errors = 0;
    int measure_errors = 0;
    logic done_last = 1'b0;

    assign error_count = level_errors + measure_errors;

    // Centre aligned pulse from period/2 - duty/2 up to period/2 + duty/2
    function automatic int expected_high_cycles(input int period_value, input int duty_value);
        int half_period;
        int half_duty;
        half_period = period_value / 2;
        half_duty = duty_value / 2;
        return (half_period + half_duty) - (half_period - half_duty);
    endfunction

    // The counter runs from 0 to period-1
    function automatic int expected_period(input int period_value);
        return period_value;
    endfunction

    // Steps to a rising edge of one phase, then counts its high run and the low run after it
    task automatic measure_phase(input int phase, output int high_cycles,
            output int period_cycles, output bit toggled);
        int guard;
        guard = 0;
        high_cycles = 0;
        while (pwm[phase] && guard < phase_limit) begin
            @(posedge clock);
            guard++;
        end
        while (!pwm[phase] && guard < phase_limit) begin
            @(posedge clock);
            guard++;
        end
        while (pwm[phase] && guard < phase_limit) begin
            high_cycles++;
            @(posedge clock);
            guard++;
        end
        period_cycles = high_cycles;
        while (!pwm[phase] && guard < phase_limit) begin
            period_cycles++;
            @(posedge clock);
            guard++;
        end
        toggled = (guard < phase_limit);
    endtask

    // Levels that must hold on every cycle once reset is released
    always @(posedge clock) begin
        if (reset) begin
            if (modulator_status !== expected_status) begin
                $display("Error [%0s] modulator_status: expected %0b, actual %0b",
                    test_name, expected_status, modulator_status);
                level_errors++;
            end
            if (pwm_quiet && pwm !== '0) begin
                $display("Error [%0s] pwm outputs: expected %b, actual %b",
                    test_name, `VSI_N_PHASES'(0), pwm);
                level_errors++;
            end
            if (done && !done_window) begin
                $display("The done output pulsed outside a configure sequence during %0s",
                    test_name);
                level_errors++;
            end
            if (done && done_last) begin
                $display("The done output stayed high for more than one cycle");
                level_errors++;
            end
            done_last = done;
        end else begin
            done_last = 1'b0;
        end
    end

    initial begin
        int high_cycles;
        int period_cycles;
        bit toggled;
        measure_done = 1'b0;
        forever begin
            @(posedge clock);
            if (!measure_request) begin
                measure_done = 1'b0;
            end else if (!measure_done) begin
                for (int i = 0; i < `VSI_N_PHASES; i++) begin
                    measure_phase(i, high_cycles, period_cycles, toggled);
                    if (!toggled) begin
                        $display("Phase %0d never completed a PWM period during %0s",
                            i, test_name);
                        measure_errors++;
                    end else begin
                        if (period_cycles != expected_period(int'(measure_period))) begin
                            $display("Error [%0s] phase %0d period: expected %0d, actual %0d",
                                test_name, i, expected_period(int'(measure_period)),
                                period_cycles);
                            measure_errors++;
                        end
                        if (high_cycles != expected_high_cycles(int'(measure_period),
                                int'(measure_duty[i]))) begin
                            $display("Error [%0s] phase %0d high cycles: expected %0d, actual %0d",
                                test_name, i, expected_high_cycles(int'(measure_period),
                                int'(measure_duty[i])), high_cycles);
                            measure_errors++;
                        end
                    end
                end
                measure_done = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_vsi_modulation.sv
`timescale 1ns/1ns
`default_nettype none

`include "vsi_settings.svh"

module tb_vsi_modulation;

    localparam int clock_period = 20;
    localparam int max_period = 128;
    localparam int phase_limit = 4 * max_period;
    localparam int measure_limit = `VSI_N_PHASES * phase_limit + 8;
    localparam int done_limit = 64;
    localparam int settle_cycles = 80;
    localparam int quiet_cycles = 10;
    localparam int random_rounds = 10;
    // One measurement after the first start, two around the running update, one per round
    localparam int run_checks = random_rounds + 3;
    localparam int test_cycles =
        run_checks * (2 * settle_cycles + quiet_cycles + measure_limit + 8) + done_limit + 100;
    localparam int watchdog_margin = 2000;

    typedef logic [`VSI_DATA_WIDTH-1:0] duty_set_t [`VSI_N_PHASES];

    logic clock = 1'b0;
    logic reset;
    logic configure;
    logic start;
    logic stop;
    logic [`VSI_N_PHASES-1:0] update;
    logic [`VSI_DATA_WIDTH-1:0] period;
    duty_set_t duty;
    logic done;
    logic modulator_status;
    logic [`VSI_N_PHASES-1:0] pwm;

    logic [8*24-1:0] test_name;
    logic expected_status;
    logic done_window;
    logic pwm_quiet;
    logic measure_request;
    logic measure_done;
    logic [`VSI_DATA_WIDTH-1:0] measure_period;
    duty_set_t measure_duty;
    int error_count;
    int failure_count;
    int seed;

    always #(clock_period / 2) clock = ~clock;

    vsi_modulation_top u_dut (.*);

    pwm_checker #(.phase_limit(phase_limit)) u_checker (.*);

    task automatic wait_cycles(input int count);
        repeat (count) @(negedge clock);
    endtask

    task automatic run_configure();
        bit seen;
        seen = 1'b0;
        configure = 1'b1;
        done_window = 1'b1;
        @(negedge clock);
        configure = 1'b0;
        for (int i = 0; i < done_limit && !seen; i++) begin
            @(negedge clock);
            seen = done;
        end
        if (!seen) begin
            $display("Configure gave no done pulse within %0d cycles", done_limit);
            failure_count++;
        end
        // The window stays open one more cycle so a stretched pulse is still caught
        @(negedge clock);
        done_window = 1'b0;
    endtask

    // Status follows on the cycle after the pulse
    task automatic pulse_control(input logic run);
        if (run) begin
            pwm_quiet = 1'b0;
            start = 1'b1;
        end else begin
            stop = 1'b1;
        end
        @(negedge clock);
        start = 1'b0;
        stop = 1'b0;
        expected_status = run;
    endtask

    task automatic stop_modulator();
        pulse_control(1'b0);
        wait_cycles(quiet_cycles);
        pwm_quiet = 1'b1;
        wait_cycles(settle_cycles);
    endtask

    task automatic apply_update(input int period_value, input duty_set_t values,
            input logic [`VSI_N_PHASES-1:0] strobe);
        period = `VSI_DATA_WIDTH'(period_value);
        duty = values;
        update = strobe;
        @(negedge clock);
        update = '0;
    endtask

    task automatic check_outputs(input int period_value, input duty_set_t values);
        bit finished;
        finished = 1'b0;
        measure_period = `VSI_DATA_WIDTH'(period_value);
        measure_duty = values;
        measure_request = 1'b1;
        for (int i = 0; i < measure_limit && !finished; i++) begin
            @(negedge clock);
            finished = measure_done;
        end
        if (!finished) begin
            $display("PWM measurement in %0s did not finish within %0d cycles",
                test_name, measure_limit);
            failure_count++;
        end
        measure_request = 1'b0;
        @(negedge clock);
    endtask

    initial begin
        duty_set_t first_duty;
        duty_set_t second_duty;
        duty_set_t random_duty;
        int random_period;
        seed = 72;
        reset = 1'b0;
        configure = 1'b0;
        start = 1'b0;
        stop = 1'b0;
        update = '0;
        period = '0;
        duty = '{default: '0};
        test_name = "reset";
        expected_status = 1'b0;
        done_window = 1'b0;
        pwm_quiet = 1'b1;
        measure_request = 1'b0;
        measure_period = '0;
        measure_duty = '{default: '0};
        failure_count = 0;
        first_duty = '{20, 50, 81, 119};
        second_duty = '{10, 33, 60, 88};

        repeat (3) @(negedge clock);
        reset = 1'b1;
        wait_cycles(4);

        test_name = "configure";
        run_configure();
        wait_cycles(settle_cycles);

        test_name = "update then start";
        apply_update(120, first_duty, 4'b0001);
        wait_cycles(settle_cycles);
        pulse_control(1'b1);
        check_outputs(120, first_duty);

        test_name = "stop";
        stop_modulator();

        // New duties wait in the calculator until the next stop
        test_name = "update while running";
        pulse_control(1'b1);
        apply_update(90, second_duty, 4'b0100);
        wait_cycles(settle_cycles);
        check_outputs(120, first_duty);
        stop_modulator();
        pulse_control(1'b1);
        check_outputs(90, second_duty);
        stop_modulator();

        test_name = "random duties";
        for (int round = 0; round < random_rounds; round++) begin
            random_period = 16 + int'({$random(seed)} % 100);
            for (int i = 0; i < `VSI_N_PHASES; i++) begin
                random_duty[i] = `VSI_DATA_WIDTH'(2 + {$random(seed)} % (random_period - 2));
            end
            apply_update(random_period, random_duty,
                `VSI_N_PHASES'(1) << (round % `VSI_N_PHASES));
            wait_cycles(settle_cycles);
            pulse_control(1'b1);
            check_outputs(random_period, random_duty);
            stop_modulator();
        end

        $display("Summary: %0d checker errors, %0d stimulus failures",
            error_count, failure_count);
        if (error_count == 0 && failure_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(test_cycles * clock_period + watchdog_margin);
        $display("Watchdog expired after %0d cycles before the tests finished", test_cycles);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+source
source/pwm_map_pkg.sv
source/modulator_ctrl_pkg.sv
source/compare_calculator.sv
source/config_sequencer.sv
source/register_write_arbiter.sv
source/pwm_generator.sv
source/vsi_modulation_top.sv
testbench/pwm_checker.sv
testbench/tb_vsi_modulation.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for failure

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -f list.f --top-module tb_vsi_modulation -Mdir "$build_dir" -o sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$build_dir/sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$log_file"; then
    exit 1
fi
exit 0
